/* loadForward.sv */
`timescale 1ns/1ps

module loadForward import lsuPkg::*; (
  input  logic     clk,
  input  logic     reset_i,
  input  logic     ldExec_i,             // load agen done
  input  addrT     ldExecAddr_i,
  input  sqPtrT    ldExecAge_i,          // age tag from dispatch
  input  dataT     ldData_i,             // memory data, one cycle after ldEn_o
  sqSearchIf.load  search,
  output logic     ldEn_o,
  output addrT     ldAddr_o,
  output logic     wbValid_o,
  output dataT     wbData_o,
  output logic     wbFwd_o               // result came from the store queue
);

  logic s1Valid;                         // load waiting for memory data
  logic s1Hit;                           // forwarding hit from stage 1
  dataT s1Data;                          // forwarded store data

  // stage 1, memory read and store queue search in parallel
  assign ldEn_o   = ldExec_i;
  assign ldAddr_o = ldExecAddr_i;

  assign search.searchValid = ldExec_i;
  assign search.searchAddr  = ldExecAddr_i;
  assign search.searchAge   = ldExecAge_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      s1Valid <= 1'b0;
      s1Hit   <= 1'b0;
    end else begin
      s1Valid <= ldExec_i;
      s1Hit   <= search.hit;             // hit already gated by searchValid
    end
  end

  always_ff @(posedge clk) begin
    s1Data <= search.hitData;            // payload only
  end

  // stage 2, store data wins over memory data
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wbValid_o <= 1'b0;
      wbFwd_o   <= 1'b0;
    end else begin
      wbValid_o <= s1Valid;
      wbFwd_o   <= s1Valid && s1Hit;
    end
  end

  always_ff @(posedge clk) begin
    wbData_o <= s1Hit ? s1Data : ldData_i;
  end

endmodule

/* lsqDispatch.sv */
`timescale 1ns/1ps

module lsqDispatch import lsuPkg::*; (
  input  logic       clk,
  input  logic       reset_i,
  input  logic       dispatchSt_i,       // store dispatched
  input  logic       dispatchLd_i,       // load dispatched
  sqAllocIf.dispatch alloc,
  output sqIdxT      stId_o,             // entry for the dispatched store
  output sqPtrT      ldAge_o,            // age tag for the dispatched load
  output sqCountT    stqCount_o,
  output logic       stqFull_o
);

  sqPtrT   tail;                         // next free entry, with wrap bit
  sqCountT count;                        // live stores

  // tail is visible in the dispatch cycle itself
  assign stId_o  = tail[SqIdxW-1:0];
  assign ldAge_o = tail;                 // stores below this tail are older

  assign alloc.allocValid = dispatchSt_i;
  assign alloc.allocIdx   = tail[SqIdxW-1:0];
  assign alloc.tail       = tail;

  assign stqCount_o = count;
  assign stqFull_o  = (count == sqCountT'(SqDepth));

  always_ff @(posedge clk) begin
    if (reset_i) begin
      tail <= '0;
    end else if (dispatchSt_i) begin
      tail <= tail + sqPtrT'(1);         // wrap bit flips every lap
    end
  end

  // count follows dispatch and commit, both together cancel out
  always_ff @(posedge clk) begin
    if (reset_i) begin
      count <= '0;
    end else begin
      case ({dispatchSt_i, alloc.commitPulse})
        2'b10:   count <= count + sqCountT'(1);
        2'b01:   count <= count - sqCountT'(1);
        default: count <= count;
      endcase
    end
  end

  // one instruction per cycle, and no store into a full queue
  assert property (@(posedge clk) disable iff (reset_i)
    !(dispatchSt_i && dispatchLd_i))
    else $error("store and load dispatched in the same cycle");

  assert property (@(posedge clk) disable iff (reset_i)
    dispatchSt_i |-> !stqFull_o)
    else $error("store dispatched while store queue full");

endmodule

/* lsuPkg.sv */
package lsuPkg;

  localparam int SqDepth = 8;            // store queue entries
  localparam int SqIdxW  = 3;            // log2 of SqDepth
  localparam int AddrW   = 8;            // word address bits
  localparam int DataW   = 32;           // full word only

  // entry index into the store queue
  typedef logic [SqIdxW-1:0] sqIdxT;

  // pointer with wrap bit, used for head, tail and load age tag
  typedef logic [SqIdxW:0] sqPtrT;

  typedef logic [AddrW-1:0] addrT;       // word address
  typedef logic [DataW-1:0] dataT;       // data word

  // 0 .. SqDepth, one extra bit for the full case
  typedef logic [SqIdxW:0] sqCountT;

  // one store entry
  typedef struct packed {
    logic addrKnown;                     // set once agen has written the entry
    addrT addr;                          // store word address
    dataT data;                          // store data
  } sqEntryT;

endpackage

/* lsuTop.sv */
`timescale 1ns/1ps

module lsuTop import lsuPkg::*; (
  input  logic    clk,
  input  logic    reset_i,
  // dispatch
  input  logic    dispatchSt_i,
  input  logic    dispatchLd_i,
  output sqIdxT   stId_o,
  output sqPtrT   ldAge_o,
  output logic    stqFull_o,
  output sqCountT stqCount_o,
  // store execute
  input  logic    stExec_i,
  input  sqIdxT   stExecId_i,
  input  addrT    stExecAddr_i,
  input  dataT    stExecData_i,
  // load execute
  input  logic    ldExec_i,
  input  addrT    ldExecAddr_i,
  input  sqPtrT   ldExecAge_i,
  // commit, store write to memory
  input  logic    commitStore_i,
  output logic    stEn_o,
  output addrT    stAddr_o,
  output dataT    stData_o,
  // memory read
  output logic    ldEn_o,
  output addrT    ldAddr_o,
  input  dataT    ldData_i,
  // writeback
  output logic    wbValid_o,
  output dataT    wbData_o,
  output logic    wbFwd_o
);

  sqAllocIf  allocIf ();                 // dispatch to store queue
  sqSearchIf searchIf ();                // load pipe to store queue

  lsqDispatch i_lsqDispatch (
    .clk          (clk),
    .reset_i      (reset_i),
    .dispatchSt_i (dispatchSt_i),
    .dispatchLd_i (dispatchLd_i),
    .alloc        (allocIf.dispatch),
    .stId_o       (stId_o),
    .ldAge_o      (ldAge_o),
    .stqCount_o   (stqCount_o),
    .stqFull_o    (stqFull_o)
  );

  storeQueue i_storeQueue (
    .clk           (clk),
    .reset_i       (reset_i),
    .stExec_i      (stExec_i),
    .stExecId_i    (stExecId_i),
    .stExecAddr_i  (stExecAddr_i),
    .stExecData_i  (stExecData_i),
    .commitStore_i (commitStore_i),
    .alloc         (allocIf.queue),
    .search        (searchIf.queue),
    .stEn_o        (stEn_o),
    .stAddr_o      (stAddr_o),
    .stData_o      (stData_o)
  );

  loadForward i_loadForward (
    .clk          (clk),
    .reset_i      (reset_i),
    .ldExec_i     (ldExec_i),
    .ldExecAddr_i (ldExecAddr_i),
    .ldExecAge_i  (ldExecAge_i),
    .ldData_i     (ldData_i),
    .search       (searchIf.load),
    .ldEn_o       (ldEn_o),
    .ldAddr_o     (ldAddr_o),
    .wbValid_o    (wbValid_o),
    .wbData_o     (wbData_o),
    .wbFwd_o      (wbFwd_o)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the store queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f src.f --top-module tbLsu -o simLsu

./obj_dir/simLsu | tee sim.log

# the run counts as passed only if the pass line reached the log
grep -q "^Test passed$" sim.log

/* sqAllocIf.sv */
`timescale 1ns/1ps

interface sqAllocIf import lsuPkg::*; ();

  logic  allocValid;                     // store dispatched this cycle
  sqIdxT allocIdx;                       // entry being allocated
  sqPtrT tail;                           // current tail incl. wrap bit
  logic  commitPulse;                    // head store retired this cycle

  // dispatch side owns tail and allocation
  modport dispatch (
    output allocValid,
    output allocIdx,
    output tail,
    input  commitPulse
  );

  // queue side clears entries and reports commits
  modport queue (
    input  allocValid,
    input  allocIdx,
    input  tail,
    output commitPulse
  );

endinterface

/* sqSearchIf.sv */
`timescale 1ns/1ps

interface sqSearchIf import lsuPkg::*; ();

  logic  searchValid;                    // load in execute
  addrT  searchAddr;                     // load word address
  sqPtrT searchAge;                      // tail seen by the load at dispatch
  logic  hit;                            // older matching store found
  dataT  hitData;                        // youngest matching store data

  // load pipe broadcasts address and age
  modport load (
    output searchValid,
    output searchAddr,
    output searchAge,
    input  hit,
    input  hitData
  );

  // store queue answers in the same cycle
  modport queue (
    input  searchValid,
    input  searchAddr,
    input  searchAge,
    output hit,
    output hitData
  );

endinterface

/* src.f */
lsuPkg.sv
sqAllocIf.sv
sqSearchIf.sv
lsqDispatch.sv
storeQueue.sv
loadForward.sv
lsuTop.sv
tbLsu.sv

/* storeQueue.sv */
`timescale 1ns/1ps

module storeQueue import lsuPkg::*; (
  input  logic     clk,
  input  logic     reset_i,
  input  logic     stExec_i,             // store agen done
  input  sqIdxT    stExecId_i,
  input  addrT     stExecAddr_i,
  input  dataT     stExecData_i,
  input  logic     commitStore_i,        // retire head store
  sqAllocIf.queue  alloc,
  sqSearchIf.queue search,
  output logic     stEn_o,
  output addrT     stAddr_o,
  output dataT     stData_o
);

  sqEntryT            entries [SqDepth]; // store entries
  sqPtrT              head;              // oldest store, with wrap bit
  sqIdxT              headIdx;
  sqPtrT              occDist;           // live stores, tail minus head
  sqPtrT              ageDist;           // stores older than the load
  sqPtrT              effAge;            // ageDist clipped to live range
  logic [SqDepth-1:0] ageMask;           // entries older than the load
  logic [SqDepth-1:0] matchVec;          // address cam result
  logic [SqDepth-1:0] hitVec;

  assign headIdx = head[SqIdxW-1:0];
  assign occDist = alloc.tail - head;    // wrap bit gives 8 when full
  assign ageDist = search.searchAge - head;

  // all older stores already retired when the tag falls behind head
  assign effAge = (ageDist <= occDist) ? ageDist : '0;

  // age mask and address match, per entry index
  always_comb begin
    sqIdxT offset;
    for (int i = 0; i < SqDepth; i++) begin
      offset      = sqIdxT'(i) - headIdx;          // distance from head
      ageMask[i]  = ({1'b0, offset} < effAge);
      matchVec[i] = entries[i].addrKnown &&        // unknown addr ignored
                    (entries[i].addr == search.searchAddr);
    end
  end

  assign hitVec = ageMask & matchVec;

  // walk from head, the last hit seen is the youngest older store
  always_comb begin
    sqIdxT idx;
    sqIdxT sel;
    logic  found;
    sel   = headIdx;
    found = 1'b0;
    for (int k = 0; k < SqDepth; k++) begin
      idx = headIdx + sqIdxT'(k);
      if (hitVec[idx]) begin
        sel   = idx;
        found = 1'b1;
      end
    end
    search.hit     = found && search.searchValid;
    search.hitData = entries[sel].data;
  end

  // entry writes, alloc clears the flag, agen fills the entry
  always_ff @(posedge clk) begin
    if (alloc.allocValid) begin
      entries[alloc.allocIdx].addrKnown <= 1'b0;
    end
    if (stExec_i) begin
      entries[stExecId_i].addrKnown <= 1'b1;
      entries[stExecId_i].addr      <= stExecAddr_i;
      entries[stExecId_i].data      <= stExecData_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      head <= '0;
    end else if (commitStore_i) begin
      head <= head + sqPtrT'(1);         // in-order retire
    end
  end

  // head entry goes straight to memory
  assign stEn_o            = commitStore_i;
  assign stAddr_o          = entries[headIdx].addr;
  assign stData_o          = entries[headIdx].data;
  assign alloc.commitPulse = commitStore_i;  // count update in dispatch

  // only a live, executed store may retire
  assert property (@(posedge clk) disable iff (reset_i)
    commitStore_i |-> (occDist != '0) && entries[headIdx].addrKnown)
    else $error("commit of empty or unexecuted store queue head");

endmodule

/* tbLsu.sv */
`timescale 1ns/1ps

module tbLsu import lsuPkg::*; ();

  logic    clk = 1'b0;
  logic    reset_i, dispatchSt_i, dispatchLd_i, stExec_i, ldExec_i, commitStore_i;
  sqIdxT   stExecId_i, stId_o;
  addrT    stExecAddr_i, ldExecAddr_i, stAddr_o, ldAddr_o;
  dataT    stExecData_i, stData_o, wbData_o;
  dataT    ldData_i = '0;                // memory read data, one cycle late
  sqPtrT   ldExecAge_i, ldAge_o;
  sqCountT stqCount_o;
  logic    stqFull_o, stEn_o, ldEn_o, wbValid_o, wbFwd_o;

  dataT        mem [256];                // memory model
  logic [31:0] lfsr = 32'd69;            // galois lfsr state
  addrT        mStAddr [64];             // reference stores by sequence number
  dataT        mStData [64];
  logic        mStExec [64];
  int          mTail, mHead, expCount;   // model tail, head, occupancy
  dataT        expData [64];             // expected writebacks in load order
  logic        expFwd [64];
  int          ldIdx, wbIdx;             // loads issued, writebacks seen
  dataT        expWbData, headData;
  logic        expWbFwd;
  addrT        headAddr;
  string       testName = "reset";

  lsuTop i_lsuTop (.*);

  initial begin
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (ldEn_o) ldData_i <= mem[ldAddr_o];       // fixed one cycle latency
    if (stEn_o) mem[stAddr_o] = stData_o;        // committed store
  end

  // model pointers move on the same edges as the DUT
  always @(posedge clk) begin
    if (reset_i) begin
      mTail    <= 0;
      mHead    <= 0;
      expCount <= 0;
      wbIdx    <= 0;
    end else begin
      if (dispatchSt_i) mTail <= mTail + 1;
      if (commitStore_i) mHead <= mHead + 1;     // oldest store retires
      expCount <= expCount + int'(dispatchSt_i) - int'(commitStore_i);
      if (wbValid_o) wbIdx <= wbIdx + 1;
    end
  end

  assign expWbData = expData[6'(wbIdx)];
  assign expWbFwd  = expFwd[6'(wbIdx)];
  assign headAddr  = mStAddr[6'(mHead)];
  assign headData  = mStData[6'(mHead)];

  task automatic stopOnError();
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic reportMismatch(input string what, input logic [63:0] expV,
                                input logic [63:0] actV);
    $display("Mismatch in %s on %s: expected %0h, actual %0h", testName, what, expV, actV);
    stopOnError();
  endtask

  // one lfsr step per bit, bits shifted in from the top
  task automatic randWord(output dataT w);
    for (int b = 0; b < DataW; b++) begin
      w    = {lfsr[0], w[DataW-1:1]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
  endtask

  assert property (@(posedge clk) $fell(reset_i) |->
    !wbValid_o && !stEn_o && !ldEn_o && !stqFull_o && stqCount_o == '0)
    else begin
      $display("outputs not idle right after reset");
      stopOnError();
    end

  assert property (@(posedge clk) disable iff (reset_i) ldExec_i |-> ##2 wbValid_o)
    else begin
      $display("no writeback two cycles after a load execute");
      stopOnError();
    end

  assert property (@(posedge clk) disable iff (reset_i) wbValid_o |-> $past(ldExec_i, 2))
    else begin
      $display("writeback without a load execute two cycles before");
      stopOnError();
    end

  assert property (@(posedge clk) disable iff (reset_i)
    wbValid_o |-> wbData_o == expWbData)
    else reportMismatch("wbData_o", 64'($sampled(expWbData)), 64'($sampled(wbData_o)));

  assert property (@(posedge clk) disable iff (reset_i)
    wbValid_o |-> wbFwd_o == expWbFwd)
    else reportMismatch("wbFwd_o", 64'($sampled(expWbFwd)), 64'($sampled(wbFwd_o)));

  // memory read strobe and address in the execute cycle
  assert property (@(posedge clk) disable iff (reset_i) ldEn_o == ldExec_i)
    else reportMismatch("ldEn_o", 64'($sampled(ldExec_i)), 64'($sampled(ldEn_o)));

  assert property (@(posedge clk) disable iff (reset_i)
    ldExec_i |-> ldAddr_o == ldExecAddr_i)
    else reportMismatch("ldAddr_o", 64'($sampled(ldExecAddr_i)), 64'($sampled(ldAddr_o)));

  // memory write strobe only in commit cycles
  assert property (@(posedge clk) disable iff (reset_i) stEn_o == commitStore_i)
    else reportMismatch("stEn_o", 64'($sampled(commitStore_i)), 64'($sampled(stEn_o)));

  assert property (@(posedge clk) disable iff (reset_i)
    stEn_o |-> {stAddr_o, stData_o} == {headAddr, headData})
    else reportMismatch("stAddr_o,stData_o", 64'($sampled({headAddr, headData})),
                        64'($sampled({stAddr_o, stData_o})));

  assert property (@(posedge clk) disable iff (reset_i)
    {stqFull_o, stqCount_o} == {expCount == SqDepth, sqCountT'(expCount)})
    else reportMismatch("stqFull_o,stqCount_o",
                        64'($sampled({expCount == SqDepth, sqCountT'(expCount)})),
                        64'($sampled({stqFull_o, stqCount_o})));

  assert property (@(posedge clk) disable iff (reset_i)
    dispatchSt_i |-> stId_o == sqIdxT'(mTail))
    else reportMismatch("stId_o", 64'($sampled(sqIdxT'(mTail))), 64'($sampled(stId_o)));

  assert property (@(posedge clk) disable iff (reset_i)
    dispatchLd_i |-> ldAge_o == sqPtrT'(mTail))
    else reportMismatch("ldAge_o", 64'($sampled(sqPtrT'(mTail))), 64'($sampled(ldAge_o)));

  // all stimulus tasks start and end on a falling edge
  task automatic dispatchStore(output int seq, input logic alsoCommit);
    seq              = mTail;
    mStExec[6'(seq)] = 1'b0;             // allocated, address unknown
    dispatchSt_i     = 1'b1;
    commitStore_i    = alsoCommit;
    @(negedge clk);
    dispatchSt_i  = 1'b0;
    commitStore_i = 1'b0;
  endtask

  task automatic dispatchLoad(output int age);
    age          = mTail;                // stores below this tag are older
    dispatchLd_i = 1'b1;
    @(negedge clk);
    dispatchLd_i = 1'b0;
  endtask

  task automatic execStore(input int seq, input addrT a, input dataT d);
    stExec_i     = 1'b1;
    stExecId_i   = sqIdxT'(seq);
    stExecAddr_i = a;
    stExecData_i = d;
    @(negedge clk);
    stExec_i         = 1'b0;
    mStAddr[6'(seq)] = a;
    mStData[6'(seq)] = d;
    mStExec[6'(seq)] = 1'b1;
  endtask

  task automatic execLoad(input int age, input addrT a);
    logic found;
    found              = 1'b0;
    expData[6'(ldIdx)] = mem[a];         // default is the memory word
    expFwd[6'(ldIdx)]  = 1'b0;
    // youngest older store first, unexecuted ones skipped
    for (int s = age - 1; s >= mHead && !found; s--) begin
      if (mStExec[6'(s)] && mStAddr[6'(s)] == a) begin
        expData[6'(ldIdx)] = mStData[6'(s)];
        expFwd[6'(ldIdx)]  = 1'b1;
        found              = 1'b1;
      end
    end
    ldIdx++;
    ldExec_i     = 1'b1;
    ldExecAddr_i = a;
    ldExecAge_i  = sqPtrT'(age);
    @(negedge clk);
    ldExec_i = 1'b0;
  endtask

  task automatic commitStores(input int n);
    repeat (n) begin
      commitStore_i = 1'b1;              // head store each cycle
      @(negedge clk);
    end
    commitStore_i = 1'b0;
  endtask

  task automatic drainLoads();
    int guard;
    guard = 0;
    while (wbIdx != ldIdx) begin
      if (guard == 10) begin
        $display("timeout waiting for load writeback");
        stopOnError();
      end else begin
        @(negedge clk);
        guard++;
      end
    end
  endtask

  initial begin
    dataT d0;
    int   seq;
    int   seq2;
    int   age;
    reset_i       = 1'b1;
    dispatchSt_i  = 1'b0;
    dispatchLd_i  = 1'b0;
    stExec_i      = 1'b0;
    stExecId_i    = '0;
    stExecAddr_i  = '0;
    stExecData_i  = '0;
    ldExec_i      = 1'b0;
    ldExecAddr_i  = '0;
    ldExecAge_i   = '0;
    commitStore_i = 1'b0;
    for (int a = 0; a < 256; a++) begin
      randWord(d0);
      mem[8'(a)] = d0;
    end
    repeat (8) @(negedge clk);
    reset_i = 1'b0;

    testName = "noOlderStore";
    dispatchLoad(age);
    execLoad(age, 8'h10);
    drainLoads();

    testName = "forwardOne";
    dispatchStore(seq, 1'b0);
    randWord(d0);
    execStore(seq, 8'h20, d0);
    dispatchLoad(age);
    execLoad(age, 8'h20);
    drainLoads();

    testName = "youngestWins";
    for (int i = 0; i < 3; i++) dispatchStore(seq, 1'b0);
    for (int i = 0; i < 3; i++) begin    // youngest executes first
      randWord(d0);
      execStore(seq - i, 8'h30, d0);
    end
    dispatchLoad(age);
    execLoad(age, 8'h30);
    drainLoads();

    testName = "ignoredStores";
    dispatchLoad(age);
    dispatchStore(seq, 1'b0);
    randWord(d0);
    execStore(seq, 8'h40, d0);
    execLoad(age, 8'h40);                // store is younger than the load
    dispatchStore(seq, 1'b0);
    dispatchStore(seq2, 1'b0);
    randWord(d0);
    execStore(seq, 8'h50, d0);
    dispatchLoad(age);
    execLoad(age, 8'h50);                // seq2 address still unknown
    randWord(d0);
    execStore(seq2, 8'h50, d0);
    execLoad(age, 8'h50);
    drainLoads();

    testName = "commitAndWrap";
    commitStores(mTail - mHead);
    for (int i = 0; i < SqDepth; i++) dispatchStore(seq, 1'b0);
    for (int i = 0; i < SqDepth; i++) begin
      randWord(d0);
      execStore(seq - i, 8'(8'h67 - i), d0);
    end
    dispatchLoad(age);                   // tag taken while full
    execLoad(age, 8'h65);
    commitStores(4);
    dispatchStore(seq, 1'b1);            // count holds on dispatch plus commit
    dispatchStore(seq2, 1'b1);
    randWord(d0);
    execStore(seq, 8'h70, d0);
    randWord(d0);
    execStore(seq2, 8'h71, d0);
    commitStores(mTail - mHead);
    dispatchLoad(age);
    execLoad(age, 8'h63);                // committed value from memory
    execLoad(age, 8'h71);
    drainLoads();

    testName = "backToBack";
    dispatchStore(seq, 1'b0);
    randWord(d0);
    execStore(seq, 8'h80, d0);
    dispatchLoad(age);
    execLoad(age, 8'h80);
    execLoad(age, 8'h81);
    execLoad(age, 8'h80);
    execLoad(age, 8'h63);
    drainLoads();
    commitStores(1);

    $display("Test passed");
    $finish;
  end

endmodule
